// File: axi_mem_pkg.sv
package axi_mem_pkg;

  // Burst length minus one, as on AxLEN
  typedef logic [7:0] axi_len_t;

  // Log2 of the bytes per beat, as on AxSIZE
  typedef logic [2:0] axi_size_t;

  // Where a completed memory access goes
  typedef enum logic [1:0] {
    ROUTE_NONE = 2'd0, // Write beat before the last, no response
    ROUTE_R    = 2'd1, // Read beat
    ROUTE_B    = 2'd2  // Last write beat
  } resp_route_e;

  // Bytes moved by one beat of the given size
  function automatic int unsigned beat_bytes(input axi_size_t size);
    return 32'd1 << size;
  endfunction

endpackage

// File: axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned DataWidth = 64,
  parameter int unsigned IdWidth   = 4,
  parameter int unsigned NumBanks  = 2,
  parameter int unsigned BufDepth  = 1
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          ar_valid_i,
  output logic                                          ar_ready_o,
  input  logic [AddrWidth-1:0]                          ar_addr_i,
  input  logic [IdWidth-1:0]                            ar_id_i,
  input  axi_mem_pkg::axi_len_t                         ar_len_i,
  input  axi_mem_pkg::axi_size_t                        ar_size_i,
  input  logic                                          aw_valid_i,
  output logic                                          aw_ready_o,
  input  logic [AddrWidth-1:0]                          aw_addr_i,
  input  logic [IdWidth-1:0]                            aw_id_i,
  input  axi_mem_pkg::axi_len_t                         aw_len_i,
  input  axi_mem_pkg::axi_size_t                        aw_size_i,
  input  logic                                          w_valid_i,
  output logic                                          w_ready_o,
  input  logic [DataWidth-1:0]                          w_data_i,
  input  logic [DataWidth/8-1:0]                        w_strb_i,
  output logic                                          r_valid_o,
  input  logic                                          r_ready_i,
  output logic [DataWidth-1:0]                          r_data_o,
  output logic [IdWidth-1:0]                            r_id_o,
  output logic                                          r_last_o,
  output logic                                          b_valid_o,
  input  logic                                          b_ready_i,
  output logic [IdWidth-1:0]                            b_id_o,
  output logic                                          busy_o,
  output logic [NumBanks-1:0]                           bank_req_o,
  input  logic [NumBanks-1:0]                           bank_gnt_i,
  output logic [NumBanks-1:0][AddrWidth-1:0]            bank_addr_o,
  output logic [NumBanks-1:0][DataWidth/NumBanks-1:0]   bank_wdata_o,
  output logic [NumBanks-1:0][DataWidth/NumBanks/8-1:0] bank_strb_o,
  output logic [NumBanks-1:0]                           bank_we_o,
  input  logic [NumBanks-1:0]                           bank_rvalid_i,
  input  logic [NumBanks-1:0][DataWidth/NumBanks-1:0]   bank_rdata_i
);
  import axi_mem_pkg::*;

  logic                   rd_valid, rd_ready, rd_last, rd_active;
  logic [AddrWidth-1:0]   rd_addr;
  logic [IdWidth-1:0]     rd_id;
  logic                   wr_valid, wr_ready, wr_last, wr_active;
  logic [AddrWidth-1:0]   wr_addr;
  logic [IdWidth-1:0]     wr_id;
  logic [DataWidth-1:0]   wr_data;
  logic [DataWidth/8-1:0] wr_strb;
  logic                   meta_valid, meta_ready, meta_last;
  logic [IdWidth-1:0]     meta_id;
  resp_route_e            meta_route;
  logic                   mem_req, mem_gnt, mem_we, mem_rvalid, mem_rready;
  logic [AddrWidth-1:0]   mem_addr;
  logic [DataWidth-1:0]   mem_wdata, mem_rdata;
  logic [DataWidth/8-1:0] mem_strb;
  logic                   pending;

  assign busy_o = ar_valid_i | aw_valid_i | w_valid_i | r_valid_o | b_valid_o |
                  rd_active | wr_active | pending;

  rd_burst_gen #(
    .AddrWidth (AddrWidth),
    .IdWidth   (IdWidth)
  ) u_rd_gen (
    .clk_i, .rst_ni, .ar_valid_i, .ar_ready_o, .ar_addr_i, .ar_id_i, .ar_len_i, .ar_size_i,
    .rd_valid_o (rd_valid), .rd_ready_i (rd_ready), .rd_addr_o (rd_addr),
    .rd_id_o (rd_id), .rd_last_o (rd_last), .rd_active_o (rd_active)
  );

  wr_burst_gen #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .IdWidth   (IdWidth)
  ) u_wr_gen (
    .clk_i, .rst_ni, .aw_valid_i, .aw_ready_o, .aw_addr_i, .aw_id_i, .aw_len_i, .aw_size_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
    .wr_valid_o (wr_valid), .wr_ready_i (wr_ready), .wr_addr_o (wr_addr),
    .wr_id_o (wr_id), .wr_last_o (wr_last), .wr_data_o (wr_data),
    .wr_strb_o (wr_strb), .wr_active_o (wr_active)
  );

  rw_arbiter #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .IdWidth   (IdWidth)
  ) u_arb (
    .clk_i, .rst_ni,
    .rd_valid_i (rd_valid), .rd_ready_o (rd_ready), .rd_addr_i (rd_addr),
    .rd_id_i (rd_id), .rd_last_i (rd_last), .rd_active_i (rd_active),
    .wr_valid_i (wr_valid), .wr_ready_o (wr_ready), .wr_addr_i (wr_addr),
    .wr_id_i (wr_id), .wr_last_i (wr_last), .wr_data_i (wr_data),
    .wr_strb_i (wr_strb), .wr_active_i (wr_active),
    .meta_ready_i (meta_ready), .mem_gnt_i (mem_gnt),
    .meta_valid_o (meta_valid), .meta_id_o (meta_id), .meta_last_o (meta_last),
    .meta_route_o (meta_route), .mem_req_o (mem_req), .mem_addr_o (mem_addr),
    .mem_wdata_o (mem_wdata), .mem_strb_o (mem_strb), .mem_we_o (mem_we)
  );

  resp_path #(
    .DataWidth (DataWidth),
    .IdWidth   (IdWidth),
    .BufDepth  (BufDepth)
  ) u_resp (
    .clk_i, .rst_ni,
    .meta_valid_i (meta_valid), .meta_ready_o (meta_ready), .meta_id_i (meta_id),
    .meta_last_i (meta_last), .meta_route_i (meta_route),
    .mem_rvalid_i (mem_rvalid), .mem_rready_o (mem_rready), .mem_rdata_i (mem_rdata),
    .r_valid_o, .r_ready_i, .r_data_o, .r_id_o, .r_last_o,
    .b_valid_o, .b_ready_i, .b_id_o, .pending_o (pending)
  );

  bank_splitter #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .NumBanks  (NumBanks)
  ) u_banks (
    .clk_i, .rst_ni,
    .mem_req_i (mem_req), .mem_gnt_o (mem_gnt), .mem_addr_i (mem_addr),
    .mem_wdata_i (mem_wdata), .mem_strb_i (mem_strb), .mem_we_i (mem_we),
    .mem_rvalid_o (mem_rvalid), .mem_rready_i (mem_rready), .mem_rdata_o (mem_rdata),
    .bank_req_o, .bank_gnt_i, .bank_addr_o, .bank_wdata_o, .bank_strb_o,
    .bank_we_o, .bank_rvalid_i, .bank_rdata_i
  );

endmodule

// File: bank_splitter.sv
`timescale 1ns/1ps

module bank_splitter #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned DataWidth = 64,
  parameter int unsigned NumBanks  = 2
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         mem_req_i,
  output logic                                         mem_gnt_o,
  input  logic [AddrWidth-1:0]                         mem_addr_i,
  input  logic [DataWidth-1:0]                         mem_wdata_i,
  input  logic [DataWidth/8-1:0]                       mem_strb_i,
  input  logic                                         mem_we_i,
  output logic                                         mem_rvalid_o,
  input  logic                                         mem_rready_i,
  output logic [DataWidth-1:0]                         mem_rdata_o,
  output logic [NumBanks-1:0]                          bank_req_o,
  input  logic [NumBanks-1:0]                          bank_gnt_i,
  output logic [NumBanks-1:0][AddrWidth-1:0]           bank_addr_o,
  output logic [NumBanks-1:0][DataWidth/NumBanks-1:0]  bank_wdata_o,
  output logic [NumBanks-1:0][DataWidth/NumBanks/8-1:0] bank_strb_o,
  output logic [NumBanks-1:0]                          bank_we_o,
  input  logic [NumBanks-1:0]                          bank_rvalid_i,
  input  logic [NumBanks-1:0][DataWidth/NumBanks-1:0]  bank_rdata_i
);

  localparam int unsigned BankBits  = DataWidth / NumBanks;
  localparam int unsigned BankBytes = BankBits / 8;
  localparam int unsigned WordBytes = DataWidth / 8;

  logic [AddrWidth-1:0]               word_addr;
  logic [NumBanks-1:0]                wait_q;      // Granted by bank, answer not back yet
  logic [NumBanks-1:0]                rsp_valid_q;
  logic [NumBanks-1:0][BankBits-1:0]  rsp_data_q;
  logic [NumBanks-1:0]                rsp_avail;
  logic                               load, pop;

  assign word_addr = mem_addr_i & ~AddrWidth'(WordBytes - 1);

  // One access in flight per bank, request and response stages included
  assign mem_gnt_o = ~|(bank_req_o | wait_q | rsp_valid_q);
  assign load      = mem_req_i & mem_gnt_o;

  // Responses fall through until the last bank has answered
  assign rsp_avail    = rsp_valid_q | bank_rvalid_i;
  assign mem_rvalid_o = &rsp_avail;
  assign pop          = mem_rvalid_o & mem_rready_i;

  always_comb begin
    for (int i = 0; i < NumBanks; i++) begin
      mem_rdata_o[i*BankBits +: BankBits] = rsp_valid_q[i] ? rsp_data_q[i] : bank_rdata_i[i];
    end
  end

  // Request payload, one slice per bank
  always_ff @(posedge clk_i) begin
    if (load) begin
      for (int i = 0; i < NumBanks; i++) begin
        bank_addr_o[i]  <= word_addr + AddrWidth'(i * BankBytes);
        bank_wdata_o[i] <= mem_wdata_i[i*BankBits +: BankBits];
        bank_strb_o[i]  <= mem_strb_i[i*BankBytes +: BankBytes];
        bank_we_o[i]    <= mem_we_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumBanks; i++) begin
      if (bank_rvalid_i[i] && !rsp_valid_q[i]) begin
        rsp_data_q[i] <= bank_rdata_i[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_req_o  <= '0;
      wait_q      <= '0;
      rsp_valid_q <= '0;
    end else begin
      for (int i = 0; i < NumBanks; i++) begin
        if (load) begin
          bank_req_o[i] <= 1'b1;
        end else if (bank_gnt_i[i]) begin
          bank_req_o[i] <= 1'b0;
        end
        if (bank_req_o[i] && bank_gnt_i[i]) begin
          wait_q[i] <= 1'b1;
        end else if (bank_rvalid_i[i]) begin
          wait_q[i] <= 1'b0;
        end
        if (pop) begin
          rsp_valid_q[i] <= 1'b0;
        end else if (bank_rvalid_i[i]) begin
          rsp_valid_q[i] <= 1'b1; // Hold until the other banks answer
        end
      end
    end
  end

endmodule

// File: project.f
axi_mem_pkg.sv
rd_burst_gen.sv
wr_burst_gen.sv
rw_arbiter.sv
resp_path.sv
bank_splitter.sv
axi_mem_top.sv
tb_clk_gen.sv
tb_axi_mem.sv

// File: rd_burst_gen.sv
`timescale 1ns/1ps

module rd_burst_gen #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned IdWidth   = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  logic [AddrWidth-1:0]   ar_addr_i,
  input  logic [IdWidth-1:0]     ar_id_i,
  input  axi_mem_pkg::axi_len_t  ar_len_i,
  input  axi_mem_pkg::axi_size_t ar_size_i,
  output logic                   rd_valid_o,
  input  logic                   rd_ready_i,
  output logic [AddrWidth-1:0]   rd_addr_o,
  output logic [IdWidth-1:0]     rd_id_o,
  output logic                   rd_last_o,
  output logic                   rd_active_o
);
  import axi_mem_pkg::*;

  axi_len_t             cnt_q;   // Beats still to issue
  axi_len_t             rem;
  axi_size_t            size_q;
  axi_size_t            size_sel;
  logic [AddrWidth-1:0] addr_q;  // Next beat address, already aligned
  logic [AddrWidth-1:0] step;
  logic [IdWidth-1:0]   id_q;
  logic                 take;

  assign rd_active_o = (cnt_q != '0);
  assign rd_valid_o  = rd_active_o | ar_valid_i;
  assign rd_addr_o   = rd_active_o ? addr_q : ar_addr_i; // First beat keeps its offset
  assign rd_id_o     = rd_active_o ? id_q : ar_id_i;
  assign size_sel    = rd_active_o ? size_q : ar_size_i;
  assign step        = AddrWidth'(beat_bytes(size_sel));

  // Remaining count after this beat
  assign rem        = rd_active_o ? cnt_q - 8'd1 : ar_len_i;
  assign rd_last_o  = (rem == '0);
  assign ar_ready_o = ~rd_active_o & rd_ready_i;
  assign take       = rd_valid_o & rd_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (take) begin
      cnt_q <= rem;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      addr_q <= (rd_addr_o & ~(step - 1'b1)) + step; // Step from the aligned base
      if (!rd_active_o) begin
        id_q   <= ar_id_i;
        size_q <= ar_size_i;
      end
    end
  end

endmodule

// File: resp_path.sv
`timescale 1ns/1ps

module resp_path #(
  parameter int unsigned DataWidth = 64,
  parameter int unsigned IdWidth   = 4,
  parameter int unsigned BufDepth  = 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     meta_valid_i,
  output logic                     meta_ready_o,
  input  logic [IdWidth-1:0]       meta_id_i,
  input  logic                     meta_last_i,
  input  axi_mem_pkg::resp_route_e meta_route_i,
  input  logic                     mem_rvalid_i,
  output logic                     mem_rready_o,
  input  logic [DataWidth-1:0]     mem_rdata_i,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  output logic [DataWidth-1:0]     r_data_o,
  output logic [IdWidth-1:0]       r_id_o,
  output logic                     r_last_o,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  output logic [IdWidth-1:0]       b_id_o,
  output logic                     pending_o
);
  import axi_mem_pkg::*;

  localparam int unsigned Depth = BufDepth + 1;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  logic [IdWidth-1:0] id_mem    [Depth];
  logic               last_mem  [Depth];
  resp_route_e        route_mem [Depth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            empty, push, pop;
  resp_route_e     head_route;

  assign empty        = (cnt_q == '0);
  assign meta_ready_o = (cnt_q != CntW'(Depth));
  assign push         = meta_valid_i & meta_ready_o;
  assign head_route   = route_mem[rd_ptr_q];
  assign pending_o    = ~empty;

  // Join the memory response with the head entry and steer it
  assign r_valid_o = ~empty & mem_rvalid_i & (head_route == ROUTE_R);
  assign b_valid_o = ~empty & mem_rvalid_i & (head_route == ROUTE_B);

  always_comb begin
    case (head_route)
      ROUTE_R: mem_rready_o = ~empty & r_ready_i;
      ROUTE_B: mem_rready_o = ~empty & b_ready_i;
      default: mem_rready_o = ~empty; // Dropped without output
    endcase
  end

  assign pop      = mem_rvalid_i & mem_rready_o;
  assign r_data_o = mem_rdata_i;
  assign r_id_o   = id_mem[rd_ptr_q];
  assign r_last_o = last_mem[rd_ptr_q];
  assign b_id_o   = id_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr_q]    <= meta_id_i;
      last_mem[wr_ptr_q]  <= meta_last_i;
      route_mem[wr_ptr_q] <= meta_route_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_axi_mem -f project.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "No result line found in sim.log"
  exit 1
fi
exit 0

// File: rw_arbiter.sv
`timescale 1ns/1ps

module rw_arbiter #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned DataWidth = 64,
  parameter int unsigned IdWidth   = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rd_valid_i,
  output logic                     rd_ready_o,
  input  logic [AddrWidth-1:0]     rd_addr_i,
  input  logic [IdWidth-1:0]       rd_id_i,
  input  logic                     rd_last_i,
  input  logic                     rd_active_i,
  input  logic                     wr_valid_i,
  output logic                     wr_ready_o,
  input  logic [AddrWidth-1:0]     wr_addr_i,
  input  logic [IdWidth-1:0]       wr_id_i,
  input  logic                     wr_last_i,
  input  logic [DataWidth-1:0]     wr_data_i,
  input  logic [DataWidth/8-1:0]   wr_strb_i,
  input  logic                     wr_active_i,
  input  logic                     meta_ready_i,
  input  logic                     mem_gnt_i,
  output logic                     meta_valid_o,
  output logic [IdWidth-1:0]       meta_id_o,
  output logic                     meta_last_o,
  output axi_mem_pkg::resp_route_e meta_route_o,
  output logic                     mem_req_o,
  output logic [AddrWidth-1:0]     mem_addr_o,
  output logic [DataWidth-1:0]     mem_wdata_o,
  output logic [DataWidth/8-1:0]   mem_strb_o,
  output logic                     mem_we_o
);
  import axi_mem_pkg::*;

  logic sel_q, sel;  // High selects the write side
  logic lock_q;
  logic sel_valid, can_issue, issue;

  always_comb begin
    sel = sel_q;
    if (!lock_q) begin
      if (wr_valid_i ^ rd_valid_i) begin
        sel = wr_valid_i;
      end else if (wr_valid_i && rd_valid_i) begin
        if (wr_last_i && !rd_last_i) begin
          sel = 1'b1;     // Single write before a read burst
        end else if (wr_active_i) begin
          sel = 1'b1;
        end else if (rd_active_i) begin
          sel = 1'b0;
        end else begin
          sel = ~sel_q;   // Round robin
        end
      end
    end
  end

  // Metadata push and memory request happen together or not at all
  assign sel_valid = sel ? wr_valid_i : rd_valid_i;
  assign can_issue = meta_ready_i & mem_gnt_i;
  assign issue     = sel_valid & can_issue;

  assign rd_ready_o   = ~sel & issue;
  assign wr_ready_o   = sel & issue;
  assign meta_valid_o = issue;
  assign mem_req_o    = issue;

  assign meta_id_o    = sel ? wr_id_i : rd_id_i;
  assign meta_last_o  = sel ? wr_last_i : rd_last_i;
  assign meta_route_o = !sel ? ROUTE_R : (wr_last_i ? ROUTE_B : ROUTE_NONE);

  assign mem_addr_o  = sel ? wr_addr_i : rd_addr_i;
  assign mem_wdata_o = wr_data_i;
  assign mem_strb_o  = sel ? wr_strb_i : '0;
  assign mem_we_o    = sel;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel;
      lock_q <= sel_valid & ~can_issue; // Hold the choice until it issues
    end
  end

endmodule

// File: tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem;
  import axi_mem_pkg::*;

  localparam int unsigned AW = 16;
  localparam int unsigned DW = 64;
  localparam int unsigned IW = 4;
  localparam int unsigned NB = 2;
  localparam int unsigned NumEntries = 12;
  localparam logic [1:0] KindWr = 2'd0, KindRd = 2'd1, KindBoth = 2'd2;

  // Both kind uses addr and id for the read, addr2 and id2 for the write
  typedef struct packed {
    logic [1:0] kind;
    logic       stress;
    logic [15:0] addr;
    logic [15:0] addr2;
    axi_len_t   len;
    axi_size_t  size;
    logic [3:0] id;
    logic [3:0] id2;
    logic [7:0] strb;
  } entry_t;

  logic clk, rst_n;
  logic ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o, w_valid_i, w_ready_o;
  logic [AW-1:0] ar_addr_i, aw_addr_i;
  logic [IW-1:0] ar_id_i, aw_id_i, r_id_o, b_id_o;
  axi_len_t  ar_len_i, aw_len_i;
  axi_size_t ar_size_i, aw_size_i;
  logic [DW-1:0] w_data_i, r_data_o;
  logic [DW/8-1:0] w_strb_i;
  logic r_valid_o, r_ready_i, r_last_o, b_valid_o, b_ready_i, busy_o;
  logic [NB-1:0] bank_req_o, bank_gnt_i, bank_we_o, bank_rvalid_i;
  logic [NB-1:0][AW-1:0] bank_addr_o;
  logic [NB-1:0][DW/NB-1:0] bank_wdata_o, bank_rdata_i;
  logic [NB-1:0][DW/NB/8-1:0] bank_strb_o;

  logic [7:0]  shadow [65536];
  logic [31:0] bank_mem [NB][8192];
  entry_t      tbl [NumEntries];
  logic        table_ready = 1'b0;
  logic        stress = 1'b0;
  int          err_cnt = 0;
  logic [DW-1:0] r_data_q [$];
  logic [IW-1:0] r_id_q [$];
  logic          r_last_q [$];
  logic [IW-1:0] b_id_q [$];

  // Bank accesses seen at the falling edge, served at the next rising edge
  logic [NB-1:0] acc, acc_we;
  logic [NB-1:0][AW-1:0] acc_addr;
  logic [NB-1:0][DW/NB-1:0] acc_wdata;
  logic [NB-1:0][DW/NB/8-1:0] acc_strb;

  tb_clk_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  axi_mem_top u_dut (.clk_i(clk), .rst_ni(rst_n), .*);

  function automatic logic [7:0] fill_byte(int unsigned a);
    return 8'(a * 7) ^ 8'(a >> 8) ^ 8'h3c;
  endfunction

  function automatic logic [15:0] beat_addr(logic [15:0] start, axi_size_t size, int k);
    logic [15:0] n;
    n = 16'(beat_bytes(size));
    if (k == 0) return start;
    return (start & ~(n - 16'd1)) + 16'(k) * n;  // Later beats from the aligned base
  endfunction

  function automatic logic [7:0] lane_mask(logic [15:0] a, axi_size_t size);
    int lo, hi;
    logic [7:0] m;
    lo = int'(a % 16'd8);
    hi = int'((a & ~(16'(beat_bytes(size)) - 16'd1)) % 16'd8) + int'(beat_bytes(size)) - 1;
    for (int j = 0; j < 8; j++) m[j] = (j >= lo) && (j <= hi);
    return m;
  endfunction

  function automatic logic [DW-1:0] shadow_word(logic [15:0] a);
    logic [DW-1:0] w;
    for (int j = 0; j < 8; j++) w[j*8 +: 8] = shadow[int'(a & 16'hfff8) + j];
    return w;
  endfunction

  task automatic cmp_data(string name, logic [DW-1:0] got, logic [DW-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic cmp_id(string name, logic [IW-1:0] got, logic [IW-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic cmp_last(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic cmp_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic cmp_count(string name, int got, int exp);
    if (got != exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic drive_write(logic [15:0] addr, axi_len_t len, axi_size_t size,
                             logic [3:0] id, logic [7:0] strb);
    int beat;
    logic [15:0] ba;
    logic [DW-1:0] data;
    logic [7:0] st;
    beat = 0;
    ba   = beat_addr(addr, size, 0);
    data = {$urandom, $urandom};
    st   = lane_mask(ba, size) & strb;
    @(posedge clk);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    aw_id_i    <= id;
    aw_len_i   <= len;
    aw_size_i  <= size;
    w_valid_i  <= 1'b1;
    w_data_i   <= data;
    w_strb_i   <= st;
    while (beat <= int'(len)) begin
      @(negedge clk);
      // AW is taken only together with the first W beat
      cmp_flag("aw_ready_o", aw_ready_o, w_ready_o && (beat == 0));
      if (w_ready_o) begin
        for (int j = 0; j < 8; j++) begin
          if (st[j]) shadow[int'(ba & 16'hfff8) + j] = data[j*8 +: 8];
        end
        beat++;
        @(posedge clk);
        aw_valid_i <= 1'b0;
        if (beat <= int'(len)) begin
          ba   = beat_addr(addr, size, beat);
          data = {$urandom, $urandom};
          st   = lane_mask(ba, size) & strb;
          w_data_i <= data;
          w_strb_i <= st;
        end else begin
          w_valid_i <= 1'b0;
        end
      end
    end
  endtask

  task automatic drive_read(logic [15:0] addr, axi_len_t len, axi_size_t size, logic [3:0] id);
    @(posedge clk);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    ar_id_i    <= id;
    ar_len_i   <= len;
    ar_size_i  <= size;
    do @(negedge clk); while (!ar_ready_o);
    @(posedge clk);
    ar_valid_i <= 1'b0;
  endtask

  task automatic check_read(logic [15:0] addr, axi_len_t len, axi_size_t size, logic [3:0] id);
    cmp_count("r beat count", r_data_q.size(), int'(len) + 1);
    for (int k = 0; k < r_data_q.size(); k++) begin
      cmp_data("r_data_o", r_data_q[k], shadow_word(beat_addr(addr, size, k)));
      cmp_id("r_id_o", r_id_q[k], id);
      cmp_last("r_last_o", r_last_q[k], k == int'(len));
    end
    r_data_q.delete();
    r_id_q.delete();
    r_last_q.delete();
  endtask

  task automatic check_write(logic [3:0] id);
    cmp_count("b response count", b_id_q.size(), 1);
    if (b_id_q.size() > 0) cmp_id("b_id_o", b_id_q[0], id);
    b_id_q.delete();
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (r_valid_o && r_ready_i) begin
        r_data_q.push_back(r_data_o);
        r_id_q.push_back(r_id_o);
        r_last_q.push_back(r_last_o);
      end
      if (b_valid_o && b_ready_i) b_id_q.push_back(b_id_o);
    end
    acc       = bank_req_o & bank_gnt_i;
    acc_we    = bank_we_o;
    acc_addr  = bank_addr_o;
    acc_wdata = bank_wdata_o;
    acc_strb  = bank_strb_o;
  end

  // Bank model and random back-pressure
  always @(posedge clk) begin
    int unsigned widx;
    for (int i = 0; i < NB; i++) begin
      bank_gnt_i[i] <= stress ? 1'($urandom) : 1'b1;
      if (acc[i]) begin
        widx = int'(acc_addr[i] >> 3);
        for (int j = 0; j < 4; j++) begin
          if (acc_we[i] && acc_strb[i][j]) bank_mem[i][widx][j*8 +: 8] = acc_wdata[i][j*8 +: 8];
        end
        bank_rdata_i[i]  <= bank_mem[i][widx];
        bank_rvalid_i[i] <= 1'b1;  // One cycle after grant
      end else begin
        bank_rvalid_i[i] <= 1'b0;
      end
    end
    r_ready_i <= stress ? 1'($urandom) : 1'b1;
    b_ready_i <= stress ? 1'($urandom) : 1'b1;
  end

  initial begin
    int total;
    wait (table_ready);
    total = 0;
    for (int e = 0; e < NumEntries; e++) begin
      total += int'(tbl[e].len) + 1;
      if (tbl[e].kind == KindBoth) total += int'(tbl[e].len) + 1;
    end
    repeat (total * 200) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the table did not finish", total * 200);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int errs_before, failed;
    string kind_s;
    void'($urandom(32'h881aff4c));
    ar_valid_i    = 1'b0;
    ar_addr_i     = '0;
    ar_id_i       = '0;
    ar_len_i      = '0;
    ar_size_i     = '0;
    aw_valid_i    = 1'b0;
    aw_addr_i     = '0;
    aw_id_i       = '0;
    aw_len_i      = '0;
    aw_size_i     = '0;
    w_valid_i     = 1'b0;
    w_data_i      = '0;
    w_strb_i      = '0;
    r_ready_i     = 1'b1;
    b_ready_i     = 1'b1;
    bank_gnt_i    = '0;
    bank_rvalid_i = '0;
    bank_rdata_i  = '0;
    failed = 0;
    for (int a = 0; a < 65536; a++) begin
      shadow[a] = fill_byte(a);
      bank_mem[(a >> 2) & 1][a >> 3][(a & 3) * 8 +: 8] = fill_byte(a);
    end
    //          kind      stress addr     addr2    len    size  id     id2    strb
    tbl[0]  = '{KindWr,   1'b0, 16'h0040, 16'h0, 8'd0,  3'd3, 4'd3,  4'd0,  8'h5a};
    tbl[1]  = '{KindRd,   1'b0, 16'h0040, 16'h0, 8'd0,  3'd3, 4'd5,  4'd0,  8'hff};
    tbl[2]  = '{KindWr,   1'b0, 16'h0100, 16'h0, 8'd3,  3'd3, 4'd7,  4'd0,  8'hff};
    tbl[3]  = '{KindRd,   1'b0, 16'h0100, 16'h0, 8'd3,  3'd3, 4'd9,  4'd0,  8'hff};
    tbl[4]  = '{KindWr,   1'b0, 16'h0203, 16'h0, 8'd5,  3'd0, 4'd2,  4'd0,  8'hff};
    tbl[5]  = '{KindRd,   1'b0, 16'h0203, 16'h0, 8'd5,  3'd0, 4'd4,  4'd0,  8'hff};
    tbl[6]  = '{KindWr,   1'b1, 16'h0302, 16'h0, 8'd7,  3'd2, 4'd1,  4'd0,  8'hff};
    tbl[7]  = '{KindRd,   1'b1, 16'h0300, 16'h0, 8'd7,  3'd3, 4'd6,  4'd0,  8'hff};
    tbl[8]  = '{KindWr,   1'b1, 16'h0400, 16'h0, 8'd15, 3'd3, 4'd8,  4'd0,  8'h3c};
    tbl[9]  = '{KindRd,   1'b1, 16'h0400, 16'h0, 8'd15, 3'd3, 4'd10, 4'd0,  8'hff};
    tbl[10] = '{KindBoth, 1'b1, 16'h0100, 16'h0800, 8'd3, 3'd3, 4'd11, 4'd12, 8'hff};
    tbl[11] = '{KindRd,   1'b0, 16'h0800, 16'h0, 8'd3,  3'd3, 4'd13, 4'd0,  8'hff};
    table_ready = 1'b1;
    wait (rst_n);
    for (int e = 0; e < NumEntries; e++) begin
      errs_before = err_cnt;
      stress = tbl[e].stress;
      case (tbl[e].kind)
        KindWr: begin
          kind_s = "write";
          drive_write(tbl[e].addr, tbl[e].len, tbl[e].size, tbl[e].id, tbl[e].strb);
        end
        KindRd: begin
          kind_s = "read";
          drive_read(tbl[e].addr, tbl[e].len, tbl[e].size, tbl[e].id);
        end
        default: begin
          kind_s = "read+write";
          fork
            drive_read(tbl[e].addr, tbl[e].len, tbl[e].size, tbl[e].id);
            drive_write(tbl[e].addr2, tbl[e].len, tbl[e].size, tbl[e].id2, tbl[e].strb);
          join
          @(negedge clk);
          cmp_flag("busy_o", busy_o, 1'b1);  // Responses still outstanding
        end
      endcase
      do @(negedge clk); while (busy_o);
      if (tbl[e].kind != KindWr) check_read(tbl[e].addr, tbl[e].len, tbl[e].size, tbl[e].id);
      if (tbl[e].kind == KindWr) check_write(tbl[e].id);
      if (tbl[e].kind == KindBoth) check_write(tbl[e].id2);
      if (err_cnt != errs_before) failed++;
      $display("Test %0d %s addr %h len %0d size %0d: %s", e, kind_s, tbl[e].addr,
               tbl[e].len, tbl[e].size, (err_cnt == errs_before) ? "ok" : "FAILED");
    end
    $display("Tests run %0d, failed %0d, check errors %0d", NumEntries, failed, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HalfPeriodNs = 2,
  parameter int unsigned ResetCycles  = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;  // Release on a clock edge
  end

endmodule

// File: wr_burst_gen.sv
`timescale 1ns/1ps

module wr_burst_gen #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned DataWidth = 64,
  parameter int unsigned IdWidth   = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  logic [AddrWidth-1:0]   aw_addr_i,
  input  logic [IdWidth-1:0]     aw_id_i,
  input  axi_mem_pkg::axi_len_t  aw_len_i,
  input  axi_mem_pkg::axi_size_t aw_size_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  input  logic [DataWidth-1:0]   w_data_i,
  input  logic [DataWidth/8-1:0] w_strb_i,
  output logic                   wr_valid_o,
  input  logic                   wr_ready_i,
  output logic [AddrWidth-1:0]   wr_addr_o,
  output logic [IdWidth-1:0]     wr_id_o,
  output logic                   wr_last_o,
  output logic [DataWidth-1:0]   wr_data_o,
  output logic [DataWidth/8-1:0] wr_strb_o,
  output logic                   wr_active_o
);
  import axi_mem_pkg::*;

  axi_len_t             cnt_q;
  axi_len_t             rem;
  axi_size_t            size_q;
  axi_size_t            size_sel;
  logic [AddrWidth-1:0] addr_q;
  logic [AddrWidth-1:0] step;
  logic [IdWidth-1:0]   id_q;
  logic                 take;

  assign wr_active_o = (cnt_q != '0);

  // A beat needs W data, and the first one needs AW as well
  assign wr_valid_o = w_valid_i & (wr_active_o | aw_valid_i);
  assign wr_addr_o  = wr_active_o ? addr_q : aw_addr_i;
  assign wr_id_o    = wr_active_o ? id_q : aw_id_i;
  assign wr_data_o  = w_data_i;
  assign wr_strb_o  = w_strb_i;
  assign size_sel   = wr_active_o ? size_q : aw_size_i;
  assign step       = AddrWidth'(beat_bytes(size_sel));

  assign rem        = wr_active_o ? cnt_q - 8'd1 : aw_len_i;
  assign wr_last_o  = (rem == '0);
  assign take       = wr_valid_o & wr_ready_i;
  assign aw_ready_o = ~wr_active_o & wr_ready_i; // Together with w_ready_o on the first beat
  assign w_ready_o  = wr_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (take) begin
      cnt_q <= rem;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      addr_q <= (wr_addr_o & ~(step - 1'b1)) + step;
      if (!wr_active_o) begin
        id_q   <= aw_id_i;
        size_q <= aw_size_i;
      end
    end
  end

endmodule
